// File: src/dispatchPkg.sv
// ================================================
// Dispatch package
// shared opcode encoding, decoded fetch slots and
// issue queue entry payloads for the dispatch front
// ================================================

package dispatchPkg;

	// ================================================
	// sizes
	// ================================================

	// the deepest queue that any build may choose
	localparam int maxEntries = 64;

	// index fields are wide enough for the deepest queue
	localparam int idxBits = $clog2(maxEntries);

	// width of the tag that follows an instruction through the core
	localparam int tagBits = 11;

	// ================================================
	// opcodes
	// ================================================

	// only the classes that dispatch needs to tell apart
	typedef enum logic [2:0] {
		opAlu    = 3'd0,
		opLoad   = 3'd1,
		opStore  = 3'd2,
		opBranch = 3'd3,
		opJump   = 3'd4,
		opBreak  = 3'd5
	} opcode_e;

	// ================================================
	// records
	// ================================================

	// one decoded fetch slot
	// takeBranch marks a branch that the predictor expects to be taken
	typedef struct packed {
		logic               valid;
		opcode_e            opcode;
		logic               takeBranch;
		logic [tagBits-1:0] tag;
	} slot_t;

	// the fetched pair, slot 0 is the older instruction
	typedef slot_t [1:0] bundle_t;

	// what an issue queue entry keeps of a slot
	typedef struct packed {
		opcode_e            opcode;
		logic [tagBits-1:0] tag;
	} iqEntry_t;

	// a queue index, modules use only the low bits their depth needs
	typedef logic [idxBits-1:0] qIdx_t;

endpackage

// File: src/queueCounter.sv
// ================================================
// Queue counter
// decides how many of the two fetched slots enter
// the issue queue this cycle and tells fetch at once
// registers which slots went in at the clock edge
// ================================================

`timescale 1ns/1ps

module queueCounter #(
	parameter int IQ_ENTRIES = 16,
	parameter int WAYS = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ce,
	input  logic                    branchMiss,
	input  logic                    bundleValid,
	input  dispatchPkg::bundle_t    bundle,
	input  logic [IQ_ENTRIES-1:0]   iqValid,
	input  dispatchPkg::qIdx_t      iqTail,
	output logic [1:0]              queuedCnt,
	output logic [1:0]              queuedOnp,
	output logic [1:0]              queuedOn
);

	import dispatchPkg::*;

	// bits of a queue index that this depth actually uses
	localparam int idxW = $clog2(IQ_ENTRIES);

	// ================================================
	// free space at the tail
	// ================================================

	// the four entries starting at the tail, wrapping at the queue end
	// since the depth is a power of two the wrap is just the carry falling off
	logic [idxW-1:0] tailIdx [4];
	logic            fourFree;

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			tailIdx[k] = iqTail[idxW-1:0] + idxW'(k);
		end
	end

	// queueing waits until all four are free, which leaves headroom for a pair
	assign fourFree = !iqValid[tailIdx[0]] && !iqValid[tailIdx[1]]
		&& !iqValid[tailIdx[2]] && !iqValid[tailIdx[3]];

	// ================================================
	// slot rules
	// ================================================

	// per slot decode of the instructions that end a fetch group
	logic [1:0] isBreak;
	logic [1:0] isJump;
	logic [1:0] takeBranch;
	logic       slot0Ends;
	logic       anyStall;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			isBreak[i]    = bundle[i].opcode == opBreak;
			isJump[i]     = bundle[i].opcode == opJump;
			takeBranch[i] = bundle[i].takeBranch;
		end
	end

	// slot 1 is younger than a break, a jump or a taken branch in slot 0
	// and so belongs to a path that fetch has not chosen yet
	assign slot0Ends = isBreak[0] || isJump[0] || takeBranch[0];

	// conditions that hold back the whole bundle
	// the count also reads zero while the core is in reset
	assign anyStall = rst || branchMiss || !ce || !bundleValid || !fourFree;

	always_comb begin
		queuedOnp = 2'b00;
		// slot 0 goes in whenever nothing stalls and it holds an instruction
		if (!anyStall && bundle[0].valid) begin
			queuedOnp[0] = 1'b1;
			// slot 1 follows slot 0 only on a two way build
			if (WAYS > 1 && bundle[1].valid && !slot0Ends) begin
				queuedOnp[1] = 1'b1;
			end
		end
	end

	// slot 1 never goes in without slot 0 so the count is 0, 1 or 2
	assign queuedCnt = {1'b0, queuedOnp[0]} + {1'b0, queuedOnp[1]};

	// ================================================
	// registered copy
	// ================================================

	// shows which slots entered the queue at the last enabled edge
	always_ff @(posedge clk) begin
		if (rst) begin
			queuedOn <= 2'b00;
		end else if (ce) begin
			queuedOn <= queuedOnp;
		end
	end

endmodule

// File: src/issueQueue.sv
// ================================================
// Issue queue
// circular buffer of instruction entries, written
// at the tail by dispatch and freed by index from
// the scheduler, with one combinational read port
// ================================================

`timescale 1ns/1ps

module issueQueue #(
	parameter int IQ_ENTRIES = 16,
	parameter int WAYS = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  dispatchPkg::bundle_t    bundle,
	input  logic [1:0]              queuedOnp,
	input  logic [1:0]              queuedCnt,
	input  logic                    freeValid,
	input  dispatchPkg::qIdx_t      freeIdx,
	input  dispatchPkg::qIdx_t      readIdx,
	output logic [IQ_ENTRIES-1:0]   iqValid,
	output dispatchPkg::qIdx_t      iqTail,
	output dispatchPkg::iqEntry_t   readEntry,
	output logic                    readValid
);

	import dispatchPkg::*;

	// bits of a queue index that this depth actually uses
	localparam int idxW = $clog2(IQ_ENTRIES);

	// ================================================
	// storage
	// ================================================

	// entry payloads are only meaningful where the valid bit is set
	iqEntry_t payload [IQ_ENTRIES];

	// one bit per entry that dispatch sets and the scheduler clears
	logic [IQ_ENTRIES-1:0] valid;

	// next entry to be written
	logic [idxW-1:0] tail;

	// ================================================
	// write side
	// ================================================

	// each slot lands at the tail plus its position in the bundle
	// slot 1 is only ever enabled together with slot 0 so the two stay adjacent
	logic [idxW-1:0] wrIdx [2];

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			wrIdx[i] = tail + idxW'(i);
		end
	end

	// every enabled slot leaves its opcode and tag in the entry it lands on
	always_ff @(posedge clk) begin
		for (int i = 0; i < WAYS; i++) begin
			if (queuedOnp[i]) begin
				payload[wrIdx[i]] <= '{opcode: bundle[i].opcode, tag: bundle[i].tag};
			end
		end
	end

	// ================================================
	// valid bits and tail
	// ================================================

	// the low bits select the entry being freed
	logic [idxW-1:0] freeSel;

	assign freeSel = freeIdx[idxW-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else begin
			// clearing an entry that is already free leaves it free
			if (freeValid) begin
				valid[freeSel] <= 1'b0;
			end
			// dispatch only writes entries that the counter found free
			// so a write and a free never meet on a live entry
			for (int i = 0; i < WAYS; i++) begin
				if (queuedOnp[i]) begin
					valid[wrIdx[i]] <= 1'b1;
				end
			end
		end
	end

	// the tail moves on by the number of slots written this cycle
	// and wraps at the end of the buffer without any extra logic
	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
		end else begin
			tail <= tail + idxW'(queuedCnt);
		end
	end

	assign iqValid = valid;

	// the tail goes out as a full width index with the upper bits zero
	assign iqTail = qIdx_t'(tail);

	// ================================================
	// read port
	// ================================================

	logic [idxW-1:0] readSel;

	assign readSel = readIdx[idxW-1:0];

	// straight from the arrays with no register on the way
	assign readEntry = payload[readSel];
	assign readValid = valid[readSel];

endmodule

// File: src/dispatchTop.sv
// ================================================
// Dispatch front
// joins the queue counter and the issue queue and
// sets the queue depth and the number of ways
// ================================================

`timescale 1ns/1ps

module dispatchTop #(
	// queue depth, a power of two of at least 8
	parameter int IQ_ENTRIES = 16,
	// slots that may be queued per cycle, 1 or 2
	parameter int WAYS = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ce,
	input  logic                    branchMiss,
	input  logic                    bundleValid,
	input  dispatchPkg::bundle_t    bundle,
	input  logic                    freeValid,
	input  dispatchPkg::qIdx_t      freeIdx,
	input  dispatchPkg::qIdx_t      readIdx,
	output logic [1:0]              queuedCnt,
	output logic [1:0]              queuedOn,
	output logic [IQ_ENTRIES-1:0]   iqValid,
	output dispatchPkg::qIdx_t      iqTail,
	output dispatchPkg::iqEntry_t   readEntry,
	output logic                    readValid
);

	// per slot enable for this cycle, from the counter to the queue
	logic [1:0] queuedOnp;

	// ================================================
	// counter
	// ================================================

	// reads the occupancy and tail of the queue and answers fetch in the same cycle
	queueCounter #(
		.IQ_ENTRIES (IQ_ENTRIES),
		.WAYS       (WAYS)
	) u_counter (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.branchMiss  (branchMiss),
		.bundleValid (bundleValid),
		.bundle      (bundle),
		.iqValid     (iqValid),
		.iqTail      (iqTail),
		.queuedCnt   (queuedCnt),
		.queuedOnp   (queuedOnp),
		.queuedOn    (queuedOn)
	);

	// ================================================
	// queue
	// ================================================

	// stores whatever the counter enabled, without checking again
	issueQueue #(
		.IQ_ENTRIES (IQ_ENTRIES),
		.WAYS       (WAYS)
	) u_queue (
		.clk       (clk),
		.rst       (rst),
		.bundle    (bundle),
		.queuedOnp (queuedOnp),
		.queuedCnt (queuedCnt),
		.freeValid (freeValid),
		.freeIdx   (freeIdx),
		.readIdx   (readIdx),
		.iqValid   (iqValid),
		.iqTail    (iqTail),
		.readEntry (readEntry),
		.readValid (readValid)
	);

endmodule

// File: bench/dispatchTop_props.sv
// ==================================================
// Dispatch front properties
// concurrent checks on the count, the registered
// slot enables and the movement of the queue tail
// ==================================================

`timescale 1ns/1ps

module dispatchTop_props (
	input logic               clk,
	input logic               rst,
	input logic               branchMiss,
	input logic [1:0]         queuedCnt,
	input logic [1:0]         queuedOn,
	input dispatchPkg::qIdx_t iqTail
);

	// a branch miss flushes fetch, so nothing may enter the queue
	missBlocks: assert property (@(posedge clk) disable iff (rst)
		branchMiss |-> queuedCnt == 2'd0)
		else $error("queuedCnt nonzero during a branch miss");

	// slot 1 only ever goes in behind slot 0
	slotOrder: assert property (@(posedge clk) disable iff (rst)
		queuedOn[1] |-> queuedOn[0])
		else $error("queuedOn shows slot 1 without slot 0");

	// the tail moves exactly when slots were counted in the cycle before
	tailMoves: assert property (@(posedge clk) disable iff (rst)
		(iqTail != $past(iqTail)) == ($past(queuedCnt) != 2'd0))
		else $error("iqTail movement does not match the previous queuedCnt");

endmodule

bind dispatchTop dispatchTop_props u_props (
	.clk        (clk),
	.rst        (rst),
	.branchMiss (branchMiss),
	.queuedCnt  (queuedCnt),
	.queuedOn   (queuedOn),
	.iqTail     (iqTail)
);

// File: bench/dispatchTb.sv
// ==================================================
// Dispatch front testbench
// drives a table of fetch bundles and frees into the
// dispatch top level and checks it against a model
// of the queue occupancy, the tail and the payloads
// ==================================================

`timescale 1ns/1ps

module dispatchTb;

	import dispatchPkg::*;

	// queue depth of the default build
	localparam int depth = 16;

	logic             clk;
	logic             rst;
	logic             ce;
	logic             branchMiss;
	logic             bundleValid;
	bundle_t          bundle;
	logic             freeValid;
	qIdx_t            freeIdx;
	qIdx_t            readIdx;
	logic [1:0]       queuedCnt;
	logic [1:0]       queuedOn;
	logic [depth-1:0] iqValid;
	qIdx_t            iqTail;
	iqEntry_t         readEntry;
	logic             readValid;

	dispatchTop u_dut (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.branchMiss  (branchMiss),
		.bundleValid (bundleValid),
		.bundle      (bundle),
		.freeValid   (freeValid),
		.freeIdx     (freeIdx),
		.readIdx     (readIdx),
		.queuedCnt   (queuedCnt),
		.queuedOn    (queuedOn),
		.iqValid     (iqValid),
		.iqTail      (iqTail),
		.readEntry   (readEntry),
		.readValid   (readValid)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// ==================================================
	// stimulus table
	// ==================================================

	// ctl holds ce, branchMiss and bundleValid from the top bit down
	typedef struct packed {
		logic [2:0] ctl;
		logic [1:0] slotValid;
		opcode_e    op0;
		opcode_e    op1;
		logic [1:0] take;
		logic       freeValid;
		logic [3:0] freeIdx;
		logic [1:0] expCnt;
	} row_t;

	row_t rows [$];

	function automatic void addRow(input logic [2:0] ctl, input logic [1:0] sv,
		input opcode_e op0, input opcode_e op1, input logic [1:0] take,
		input logic fv, input logic [3:0] fi, input logic [1:0] cnt);
		row_t r;
		r = '{ctl, sv, op0, op1, take, fv, fi, cnt};
		rows.push_back(r);
	endfunction

	task automatic buildTable();
		// plain pair, then slot 0 kinds that stop slot 1, then an invalid slot 1
		addRow(3'b101, 2'b11, opAlu, opAlu, 2'b00, 1'b0, 4'd0, 2'd2);
		addRow(3'b101, 2'b11, opBreak, opAlu, 2'b00, 1'b0, 4'd0, 2'd1);
		addRow(3'b101, 2'b11, opJump, opLoad, 2'b00, 1'b0, 4'd0, 2'd1);
		addRow(3'b101, 2'b11, opBranch, opStore, 2'b01, 1'b0, 4'd0, 2'd1);
		addRow(3'b101, 2'b11, opBranch, opLoad, 2'b10, 1'b0, 4'd0, 2'd2);
		addRow(3'b101, 2'b01, opAlu, opStore, 2'b00, 1'b0, 4'd0, 2'd1);
		// ce low, branch miss and no bundle, and the last of these frees an idle entry
		addRow(3'b001, 2'b11, opAlu, opAlu, 2'b00, 1'b0, 4'd0, 2'd0);
		addRow(3'b111, 2'b11, opAlu, opAlu, 2'b00, 1'b0, 4'd0, 2'd0);
		addRow(3'b100, 2'b11, opAlu, opAlu, 2'b00, 1'b1, 4'd9, 2'd0);
		// fill up to the point where the tail region reaches live entries
		addRow(3'b101, 2'b11, opAlu, opAlu, 2'b00, 1'b0, 4'd0, 2'd2);
		addRow(3'b101, 2'b11, opLoad, opStore, 2'b00, 1'b0, 4'd0, 2'd2);
		addRow(3'b101, 2'b11, opJump, opAlu, 2'b00, 1'b0, 4'd0, 2'd1);
		addRow(3'b101, 2'b11, opAlu, opAlu, 2'b00, 1'b1, 4'd0, 2'd0);
		addRow(3'b101, 2'b11, opStore, opLoad, 2'b00, 1'b0, 4'd0, 2'd2);
		addRow(3'b101, 2'b11, opAlu, opAlu, 2'b00, 1'b1, 4'd1, 2'd0);
		addRow(3'b101, 2'b11, opAlu, opAlu, 2'b00, 1'b1, 4'd2, 2'd0);
		// this pair lands on entries 15 and 0
		addRow(3'b101, 2'b11, opLoad, opAlu, 2'b00, 1'b0, 4'd0, 2'd2);
		addRow(3'b101, 2'b11, opAlu, opAlu, 2'b00, 1'b1, 4'd3, 2'd0);
		addRow(3'b101, 2'b11, opAlu, opAlu, 2'b00, 1'b1, 4'd4, 2'd0);
		addRow(3'b101, 2'b11, opBranch, opStore, 2'b00, 1'b0, 4'd0, 2'd2);
		addRow(3'b101, 2'b11, opAlu, opAlu, 2'b00, 1'b1, 4'd0, 2'd0);
		addRow(3'b001, 2'b11, opAlu, opAlu, 2'b00, 1'b1, 4'd5, 2'd0);
	endtask

	// ==================================================
	// tags and model
	// ==================================================

	logic [15:0]        lfsr;
	logic [tagBits-1:0] tag0;
	logic [tagBits-1:0] tag1;

	// expected occupancy, tail, payloads and registered slot enables
	logic [depth-1:0]   modelValid;
	logic [3:0]         modelTail;
	logic [1:0]         modelOn;
	opcode_e            modelOp [depth];
	logic [tagBits-1:0] modelTag [depth];

	// 16 bit Fibonacci register with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one step of the register for every tag bit
	function automatic logic [tagBits-1:0] nextTag();
		logic [tagBits-1:0] t;
		t = '0;
		for (int b = 0; b < tagBits; b++) begin
			lfsr = lfsrStep(lfsr);
			t = {t[tagBits-2:0], lfsr[0]};
		end
		return t;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			failRun("a DUT output differs from the expected value");
		end
	endtask

	task automatic checkState();
		checkValue("iqValid", 64'(iqValid), 64'(modelValid));
		checkValue("iqTail", 64'(iqTail), 64'(modelTail));
		checkValue("queuedOn", 64'(queuedOn), 64'(modelOn));
	endtask

	// walks the read port over every entry and compares payloads only where valid
	task automatic scanReadPort();
		for (int k = 0; k < depth; k++) begin
			readIdx = qIdx_t'(k);
			#0.25;
			checkValue("readValid", 64'(readValid), 64'(modelValid[k]));
			if (modelValid[k]) begin
				checkValue("readEntry.opcode", 64'(readEntry.opcode), 64'(modelOp[k]));
				checkValue("readEntry.tag", 64'(readEntry.tag), 64'(modelTag[k]));
			end
		end
	endtask

	task automatic driveRow(input row_t r);
		tag0 = nextTag();
		tag1 = nextTag();
		ce = r.ctl[2];
		branchMiss = r.ctl[1];
		bundleValid = r.ctl[0];
		bundle[0] = '{valid: r.slotValid[0], opcode: r.op0, takeBranch: r.take[0], tag: tag0};
		bundle[1] = '{valid: r.slotValid[1], opcode: r.op1, takeBranch: r.take[1], tag: tag1};
		freeValid = r.freeValid;
		freeIdx = {2'b00, r.freeIdx};
	endtask

	// the next rising edge frees first and then writes the queued slots
	task automatic updateModel(input row_t r);
		logic [3:0] idx;
		if (r.freeValid) begin
			modelValid[r.freeIdx] = 1'b0;
		end
		for (int i = 0; i < 2; i++) begin
			if (r.expCnt > 2'(i)) begin
				idx = modelTail + 4'(i);
				modelValid[idx] = 1'b1;
				modelOp[idx] = (i == 0) ? r.op0 : r.op1;
				modelTag[idx] = (i == 0) ? tag0 : tag1;
			end
		end
		modelTail = modelTail + 4'(r.expCnt);
		// slots queue in order, so the count says which ones went in
		if (r.ctl[2]) begin
			modelOn = (r.expCnt == 2'd2) ? 2'b11 : {1'b0, r.expCnt[0]};
		end
	endtask

	task automatic waitResetDone();
		int n;
		n = 0;
		while (iqValid !== '0 || iqTail !== '0 || queuedOn !== 2'b00) begin
			@(negedge clk);
			n++;
			if (n > 8) begin
				failRun("queue state was not cleared within 8 cycles after reset");
			end
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		ce = 1'b0;
		branchMiss = 1'b0;
		bundleValid = 1'b0;
		bundle = '0;
		freeValid = 1'b0;
		freeIdx = '0;
		readIdx = '0;
		lfsr = 16'd56845;
		modelValid = '0;
		modelTail = '0;
		modelOn = 2'b00;
		buildTable();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		waitResetDone();
		// inputs change on the falling edge and the count is read after the port scan
		for (int n = 0; n < rows.size(); n++) begin
			@(negedge clk);
			checkState();
			driveRow(rows[n]);
			scanReadPort();
			#1;
			checkValue("queuedCnt", 64'(queuedCnt), 64'(rows[n].expCnt));
			updateModel(rows[n]);
		end
		@(negedge clk);
		checkState();
		scanReadPort();
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: tb.f
src/dispatchPkg.sv
src/queueCounter.sv
src/issueQueue.sv
src/dispatchTop.sv
bench/dispatchTop_props.sv
bench/dispatchTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the dispatch front testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module dispatchTb -o dispatchSim

# the simulator exits nonzero on a fatal check, keep going to read the log
status=0
./obj_dir/dispatchSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Done: no errors" sim.log; then
	echo "simulation stopped before it finished"
	exit 1
fi
echo "simulation PASSED"
